// File: design/cfg_pkg.sv
////////////////////////////////////////
// config register map: sizes, value and
// index types, loader states
////////////////////////////////////////
`default_nettype none

package cfg_pkg;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////
  localparam int cfg_data_w   = 16;                 // bits per register
  localparam int cfg_num_regs = 16;                 // registers in the bank
  localparam int cfg_addr_w   = $clog2(cfg_num_regs); // index width

  typedef logic [cfg_data_w-1:0] cfg_data_t;        // one register value
  typedef logic [cfg_addr_w-1:0] cfg_addr_t;        // register index

  // every register, shadow and active, comes out of reset at this value
  localparam cfg_data_t cfg_reset_value = '0;

  ////////////////////////////////////////
  // loader FSM
  ////////////////////////////////////////
  // header -> data ... data(last) -> commit -> header
  typedef enum logic [1:0] {
    cfg_header, // waiting for the start address word
    cfg_data,   // data words go to consecutive shadow regs
    cfg_commit  // one cycle, shadow copied to active
  } cfg_state_e;

endpackage

`default_nettype wire

// File: design/cdc_pkg.sv
////////////////////////////////////////
// crossing definitions shared by the
// synchronizer, handshake and stream CDC
////////////////////////////////////////
`default_nettype none

package cdc_pkg;

  // flops in every synchronizer chain
  localparam int sync_stages = 4;

  // one stream word, same width as a config register
  typedef logic [cfg_pkg::cfg_data_w-1:0] cdc_word_t;

  // held packet: last flag on top of the word
  typedef logic [cfg_pkg::cfg_data_w:0] cdc_packet_t;

endpackage

`default_nettype wire

// File: design/cdc_bit_sync.sv
////////////////////////////////////////
// multi-flop synchronizer for one level
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cdc_bit_sync (
  input  logic clk,
  input  logic reset,
  input  logic async_in, // level from the other clock domain
  output logic sync_out
);

  // sync_q[0] is the metastable catcher, top bit is safe to use
  logic [cdc_pkg::sync_stages-1:0] sync_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[cdc_pkg::sync_stages-2:0], async_in}; // shift in
    end
  end

  assign sync_out = sync_q[cdc_pkg::sync_stages-1];

  // the chain must settle to a known level once reset has been applied
  a_sync_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(sync_out))
    else $error("cdc_bit_sync: sync_out unknown after reset");

endmodule

`default_nettype wire

// File: design/cdc_handshake.sv
////////////////////////////////////////
// four-phase req/ack crossing that moves
// one held packet between clock domains
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cdc_handshake (
  input  logic                 src_clk,
  input  logic                 src_reset,
  input  cdc_pkg::cdc_packet_t src_in,   // sampled when a send starts
  input  logic                 src_send, // held high until src_rcv
  output logic                 src_rcv,  // ack seen in the source domain
  input  logic                 dest_clk,
  input  logic                 dest_reset,
  output cdc_pkg::cdc_packet_t dest_out, // stable while dest_req is high
  output logic                 dest_req,
  input  logic                 dest_ack  // driven by the consumer
);

  ////////////////////////////////////////
  // source domain
  ////////////////////////////////////////
  logic                 src_req_q;  // request level sent across
  cdc_pkg::cdc_packet_t src_hold_q; // packet held for the whole handshake

  // new send only once the previous ack has fully dropped
  logic send_start;
  assign send_start = src_send & ~src_req_q & ~src_rcv;

  always_ff @(posedge src_clk) begin
    if (send_start) begin
      src_hold_q <= src_in; // payload, no reset
    end
  end

  always_ff @(posedge src_clk) begin
    if (src_reset) begin
      src_req_q <= 1'b0;
    end else if (send_start) begin
      src_req_q <= 1'b1;
    end else if (~src_send) begin
      src_req_q <= 1'b0; // phase 3: sender withdrew, drop req
    end
  end

  // hold register only changes while req is low, so the dest side
  // samples a settled bus once the synchronized req arrives
  assign dest_out = src_hold_q;

  ////////////////////////////////////////
  // flag synchronizers
  ////////////////////////////////////////
  cdc_bit_sync req_sync_i (
    .clk      (dest_clk),
    .reset    (dest_reset),
    .async_in (src_req_q),
    .sync_out (dest_req)
  );

  cdc_bit_sync ack_sync_i (
    .clk      (src_clk),
    .reset    (src_reset),
    .async_in (dest_ack),
    .sync_out (src_rcv)
  );

  // four-phase rule: the sender keeps send up until the ack is back
  a_send_held: assert property (@(posedge src_clk) disable iff (src_reset)
    (src_send && !src_rcv) |=> src_send)
    else $error("cdc_handshake: src_send dropped before src_rcv");

endmodule

`default_nettype wire

// File: design/axis_config_reg_cdc.sv
////////////////////////////////////////
// valid/ready stream across two clocks,
// one word in flight over a req/ack CDC
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axis_config_reg_cdc (
  input  logic               src_clk,
  input  logic               src_reset,
  input  cdc_pkg::cdc_word_t src_data,
  input  logic               src_valid,
  input  logic               src_last,
  output logic               src_ready,
  input  logic               dest_clk,
  input  logic               dest_reset,
  output cdc_pkg::cdc_word_t word_data,
  output logic               word_last,
  output logic               word_valid,
  input  logic               word_ready
);

  ////////////////////////////////////////
  // source domain back-pressure
  ////////////////////////////////////////
  logic                 src_send;   // request to the handshake
  logic                 src_rcv;    // ack back from dest
  cdc_pkg::cdc_packet_t src_packet; // {last, data} of the accepted word

  // busy from acceptance until the ack has gone low again
  assign src_ready = ~(src_send | src_rcv);

  always_ff @(posedge src_clk) begin
    if (src_valid & src_ready) begin
      src_packet <= {src_last, src_data}; // capture on acceptance only
    end
  end

  always_ff @(posedge src_clk) begin
    if (src_reset) begin
      src_send <= 1'b0;
    end else if (src_valid & src_ready) begin
      src_send <= 1'b1;                   // one send per accepted word
    end else if (src_send & src_rcv) begin
      src_send <= 1'b0;                   // ack arrived, release req
    end
  end

  ////////////////////////////////////////
  // destination domain back-pressure
  ////////////////////////////////////////
  logic                 dest_req;
  logic                 dest_ack;
  cdc_pkg::cdc_packet_t dest_packet;
  logic                 xfer_done; // word taken, waiting for req to drop

  always_ff @(posedge dest_clk) begin
    {word_last, word_data} <= dest_packet; // bus is stable under req
  end

  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      word_valid <= 1'b0;
      dest_ack   <= 1'b0;
      xfer_done  <= 1'b0;
    end else if (word_valid & word_ready) begin
      word_valid <= 1'b0;      // consumed, ack the source
      dest_ack   <= 1'b1;
      xfer_done  <= 1'b1;
    end else if (~xfer_done) begin
      word_valid <= dest_req;  // holds while the loader stalls
    end else if (dest_ack & ~dest_req) begin
      dest_ack   <= 1'b0;      // req gone, re-arm for the next word
      xfer_done  <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // crossing
  ////////////////////////////////////////
  cdc_handshake cdc_handshake_i (
    .src_clk    (src_clk),
    .src_reset  (src_reset),
    .src_in     (src_packet),
    .src_send   (src_send),
    .src_rcv    (src_rcv),
    .dest_clk   (dest_clk),
    .dest_reset (dest_reset),
    .dest_out   (dest_packet),
    .dest_req   (dest_req),
    .dest_ack   (dest_ack)
  );

endmodule

`default_nettype wire

// File: design/cfg_loader_fsm.sv
////////////////////////////////////////
// packet parser: header sets the address,
// data words write shadow, last commits
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cfg_loader_fsm (
  input  logic               dest_clk,
  input  logic               dest_reset,
  input  cdc_pkg::cdc_word_t word_data,
  input  logic               word_last,
  input  logic               word_valid,
  output logic               word_ready,
  input  logic               any_written,   // a write landed this packet
  output logic               load_addr,     // header accepted
  output cfg_pkg::cfg_addr_t start_addr,
  output logic               step,          // data word accepted
  output logic               commit,        // shadow -> active
  output logic               clear_written,
  output logic               cfg_update     // one pulse per applied packet
);

  cfg_pkg::cfg_state_e state_q, state_d;
  logic                accept;

  assign word_ready = (state_q != cfg_pkg::cfg_commit); // stall during commit
  assign accept     = word_valid & word_ready;

  // header address sits in the low bits, rest of the word ignored
  assign start_addr = word_data[$bits(cfg_pkg::cfg_addr_t)-1:0];

  assign load_addr     = (state_q == cfg_pkg::cfg_header) & accept & ~word_last;
  assign step          = (state_q == cfg_pkg::cfg_data) & accept;
  assign commit        = (state_q == cfg_pkg::cfg_commit);
  assign clear_written = commit;                // flag restarts per packet
  assign cfg_update    = commit & any_written;  // silent if all words dropped

  always_comb begin
    state_d = state_q;
    case (state_q)
      cfg_pkg::cfg_header: begin
        // header with last carries no data, swallow it
        if (accept & ~word_last) state_d = cfg_pkg::cfg_data;
      end
      cfg_pkg::cfg_data: begin
        if (accept & word_last) state_d = cfg_pkg::cfg_commit;
      end
      cfg_pkg::cfg_commit: state_d = cfg_pkg::cfg_header; // single cycle
      default:             state_d = cfg_pkg::cfg_header;
    endcase
  end

  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      state_q <= cfg_pkg::cfg_header;
    end else begin
      state_q <= state_d;
    end
  end

  // upstream keeps a stalled word valid and unchanged until it is taken
  a_word_held: assert property (@(posedge dest_clk) disable iff (dest_reset)
    (word_valid && !word_ready) |=> (word_valid && $stable({word_last, word_data})))
    else $error("cfg_loader_fsm: stalled word changed or was withdrawn");

endmodule

`default_nettype wire

// File: design/cfg_burst_counter.sv
////////////////////////////////////////
// burst write address with range check
// and a per-packet written flag
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cfg_burst_counter (
  input  logic               dest_clk,
  input  logic               dest_reset,
  input  logic               load_addr,
  input  cfg_pkg::cfg_addr_t start_addr,
  input  logic               step,
  input  logic               clear_written,
  output logic               wr_en,
  output cfg_pkg::cfg_addr_t wr_addr,
  output logic               any_written
);

  cfg_pkg::cfg_addr_t next_addr_q;
  logic               out_of_range_q; // burst ran past the top register
  logic               at_top;

  assign at_top  = (next_addr_q == cfg_pkg::cfg_addr_t'(cfg_pkg::cfg_num_regs - 1));
  assign wr_en   = step & ~out_of_range_q; // extra words are dropped here
  assign wr_addr = next_addr_q;

  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      next_addr_q    <= '0;
      out_of_range_q <= 1'b0;
    end else if (load_addr) begin
      next_addr_q    <= start_addr; // new packet, new base
      out_of_range_q <= 1'b0;
    end else if (wr_en) begin
      if (at_top) out_of_range_q <= 1'b1;  // no wrap to register 0
      else        next_addr_q    <= next_addr_q + 1'b1;
    end
  end

  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      any_written <= 1'b0;
    end else if (clear_written) begin
      any_written <= 1'b0;
    end else if (wr_en) begin
      any_written <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/cfg_reg_bank.sv
////////////////////////////////////////
// shadow and active config registers,
// whole bank committed in one cycle
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cfg_reg_bank (
  input  logic               dest_clk,
  input  logic               dest_reset,
  input  logic               wr_en,
  input  cfg_pkg::cfg_addr_t wr_addr,
  input  cfg_pkg::cfg_data_t wr_data,
  input  logic               commit,
  input  cfg_pkg::cfg_addr_t rd_addr,
  output cfg_pkg::cfg_data_t rd_data
);

  cfg_pkg::cfg_data_t shadow_q [cfg_pkg::cfg_num_regs]; // staging copy
  cfg_pkg::cfg_data_t active_q [cfg_pkg::cfg_num_regs]; // what users see

  ////////////////////////////////////////
  // shadow writes
  ////////////////////////////////////////
  // untouched entries keep their last value, so a commit
  // only changes the registers the packet wrote
  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      for (int i = 0; i < cfg_pkg::cfg_num_regs; i++) begin
        shadow_q[i] <= cfg_pkg::cfg_reset_value;
      end
    end else if (wr_en) begin
      shadow_q[wr_addr] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // atomic commit
  ////////////////////////////////////////
  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      for (int i = 0; i < cfg_pkg::cfg_num_regs; i++) begin
        active_q[i] <= cfg_pkg::cfg_reset_value;
      end
    end else if (commit) begin
      active_q <= shadow_q; // every register in the same edge
    end
  end

  assign rd_data = active_q[rd_addr]; // async read port

  // loader stalls the stream during commit, so no write can race it
  a_no_write_on_commit: assert property (@(posedge dest_clk) disable iff (dest_reset)
    !(wr_en && commit))
    else $error("cfg_reg_bank: write and commit in the same cycle");

endmodule

`default_nettype wire

// File: design/cfg_cdc_top.sv
////////////////////////////////////////
// config loader top: stream CDC, packet
// parser, burst counter and register bank
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cfg_cdc_top (
  input  logic               src_clk,
  input  logic               src_reset,
  input  cdc_pkg::cdc_word_t src_data,
  input  logic               src_valid,
  input  logic               src_last,
  output logic               src_ready,
  input  logic               dest_clk,
  input  logic               dest_reset,
  input  cfg_pkg::cfg_addr_t reg_rd_addr,
  output cfg_pkg::cfg_data_t reg_rd_data,
  output logic               cfg_update
);

  // destination stream
  cdc_pkg::cdc_word_t word_data;
  logic               word_last, word_valid, word_ready;

  // loader to counter and bank
  cfg_pkg::cfg_addr_t start_addr, wr_addr;
  logic               load_addr, step, commit, clear_written;
  logic               wr_en, any_written;

  axis_config_reg_cdc cdc_i (
    .src_clk, .src_reset, .src_data, .src_valid, .src_last, .src_ready,
    .dest_clk, .dest_reset, .word_data, .word_last, .word_valid, .word_ready
  );

  cfg_loader_fsm loader_i (
    .dest_clk, .dest_reset, .word_data, .word_last, .word_valid, .word_ready,
    .any_written, .load_addr, .start_addr, .step, .commit, .clear_written,
    .cfg_update
  );

  cfg_burst_counter counter_i (
    .dest_clk, .dest_reset, .load_addr, .start_addr, .step, .clear_written,
    .wr_en, .wr_addr, .any_written
  );

  cfg_reg_bank bank_i (
    .dest_clk, .dest_reset, .wr_en, .wr_addr,
    .wr_data (word_data), // stream word is one register wide
    .commit,
    .rd_addr (reg_rd_addr),
    .rd_data (reg_rd_data)
  );

endmodule

`default_nettype wire

// File: tests/cfg_cdc_tb.sv
////////////////////////////////////////
// testbench for the config loader CDC:
// packet table, register model, checks
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cfg_cdc_tb;

  localparam int n_tests       = 10;
  localparam int word_cycles   = 50;  // worst dest cycles per word, gap plus crossing
  localparam int quiet_cycles  = 60;  // wait for packets that write nothing
  localparam int settle_cycles = 8;   // room for a stray extra pulse to show

  typedef logic [cfg_pkg::cfg_num_regs-1:0][cfg_pkg::cfg_data_w-1:0] bank_t;

  // one packet: header address, index of the word with last, gaps, chained
  typedef struct packed {
    cfg_pkg::cfg_addr_t start;
    logic [4:0]         last_pos; // 0 means last rides on the header
    logic               gaps;     // random src_valid gaps
    logic               chain;    // next packet follows with valid held high
  } pkt_t;

  pkt_t pkt_tab [n_tests] = '{
    '{4'd3,  5'd1,  1'b0, 1'b0},
    '{4'd0,  5'd1,  1'b0, 1'b0},
    '{4'd15, 5'd1,  1'b1, 1'b0},
    '{4'd5,  5'd4,  1'b1, 1'b0},
    '{4'd0,  5'd16, 1'b1, 1'b0},
    '{4'd7,  5'd0,  1'b0, 1'b0},
    '{4'd13, 5'd6,  1'b1, 1'b0}, // three writes, three dropped
    '{4'd8,  5'd3,  1'b0, 1'b1},
    '{4'd2,  5'd2,  1'b0, 1'b1},
    '{4'd14, 5'd1,  1'b0, 1'b0}
  };
  string test_name [n_tests] = '{"single_r3", "single_r0", "single_r15", "burst_r5",
    "burst_full", "header_only", "overrun_r13", "b2b_r8", "b2b_r2", "b2b_r14"};

  logic               src_clk, src_reset, dest_clk, dest_reset;
  cdc_pkg::cdc_word_t src_data;
  logic               src_valid, src_last, src_ready;
  cfg_pkg::cfg_addr_t reg_rd_addr;
  cfg_pkg::cfg_data_t reg_rd_data;
  logic               cfg_update;

  logic [31:0] rng = 32'd47170;
  bank_t       model = '0;      // expected bank once all sent packets commit
  bank_t       committed = '0;  // expected active bank right now
  bank_t       pending [$];     // snapshots waiting for their cfg_update
  int          exp_pulses = 0;
  int          pulse_count = 0;
  int          cycles = 0;
  int          limit = 0;
  logic        scan_en = 1'b1;
  string       cur_name = "reset";

  cfg_cdc_top dut (.*);

  initial begin
    dest_clk = 1'b0;
    forever #20 dest_clk = ~dest_clk;
  end

  initial begin
    src_clk = 1'b0;
    forever #14 src_clk = ~src_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int run_limit();
    int words;
    words = 0;
    for (int t = 0; t < n_tests; t++) words += pkt_tab[t].last_pos + 1;
    return 16 + words * word_cycles + (n_tests + 1) * (quiet_cycles + 40) + 200;
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  task automatic check_reg(input string name, input cfg_pkg::cfg_data_t exp,
                           input cfg_pkg::cfg_data_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "register mismatch");
    end
  endtask

  task automatic check_update(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAILED %s update pulses expected %0d actual %0d", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "update pulse count mismatch");
    end
  endtask

  task automatic check_flag(input logic ok, input string what);
    if (ok !== 1'b1) begin
      $display("error: %s", what);
      $display("TB FAILED");
      $fatal(1, "condition check failed");
    end
  endtask

  // active bank must match the committed model at every cycle,
  // new values only show up after the cfg_update cycle
  always @(negedge dest_clk) begin
    if (!dest_reset) begin
      check_reg($sformatf("%s atomic reg %0d", cur_name, reg_rd_addr),
                committed[reg_rd_addr], reg_rd_data);
      if (cfg_update) begin
        check_flag(pending.size() > 0, "cfg_update pulsed with no packet pending");
        committed = pending.pop_front(); // commit edge ends this cycle
        pulse_count++;
      end
    end
  end

  always @(posedge dest_clk) begin
    if (scan_en) reg_rd_addr <= reg_rd_addr + 1'b1; // sweep the read port
  end

  always @(posedge dest_clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: no progress after %0d dest_clk cycles", cycles);
      $display("TB FAILED");
      $fatal(1, "run timed out");
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  // entered on a src_clk rising edge, returns on the edge that took the word
  task automatic send_word(input cdc_pkg::cdc_word_t w, input logic last, input logic gaps);
    int   gap;
    logic rdy;
    gap = 0;
    if (gaps) begin
      rng = xorshift32(rng);
      gap = rng[4:0]; // often outlasts the busy window after a word
    end
    if (gap > 0) begin
      src_valid <= 1'b0;
      repeat (gap) @(posedge src_clk);
    end
    src_data  <= w;
    src_last  <= last;
    src_valid <= 1'b1;
    rdy = 1'b0;
    while (!rdy) begin
      @(negedge src_clk);
      rdy = src_ready; // stable between edges
      @(posedge src_clk);
    end
  endtask

  task automatic send_packet(input int t);
    pkt_t               p;
    cdc_pkg::cdc_word_t words [17];
    int                 addr;
    logic               wrote;
    p     = pkt_tab[t];
    addr  = p.start;
    wrote = 1'b0;
    rng   = xorshift32(rng);
    words[0] = {rng[27:16], p.start}; // junk above the address
    for (int i = 1; i <= p.last_pos; i++) begin
      rng = xorshift32(rng);
      words[i] = rng[15:0];
      if (addr < cfg_pkg::cfg_num_regs) begin // past reg 15 is dropped
        model[addr] = words[i];
        addr++;
        wrote = 1'b1;
      end
    end
    if (wrote) begin
      pending.push_back(model);
      exp_pulses++;
    end
    for (int i = 0; i <= p.last_pos; i++) send_word(words[i], i == p.last_pos, p.gaps);
  endtask

  task automatic read_all(input string name);
    @(negedge dest_clk);
    scan_en = 1'b0;
    for (int a = 0; a < cfg_pkg::cfg_num_regs; a++) begin
      @(posedge dest_clk);
      reg_rd_addr <= a;
      @(negedge dest_clk);
      check_reg($sformatf("%s reg %0d", name, a), model[a], reg_rd_data);
    end
    scan_en = 1'b1;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    src_reset   = 1'b1;
    dest_reset  = 1'b1;
    src_data    = '0;
    src_valid   = 1'b0;
    src_last    = 1'b0;
    reg_rd_addr = '0;
    limit       = run_limit();
    repeat (16) @(posedge dest_clk);
    dest_reset <= 1'b0;
    @(posedge src_clk);
    src_reset <= 1'b0;
    @(negedge src_clk);
    check_flag(src_ready, "src_ready is not high after reset");
    repeat (quiet_cycles) @(posedge dest_clk);
    check_update("after_reset", 0, pulse_count);
    read_all("after_reset");

    for (int t = 0; t < n_tests; t++) begin
      cur_name = test_name[t];
      if (t == 0 || !pkt_tab[t-1].chain) @(posedge src_clk);
      send_packet(t);
      if (!pkt_tab[t].chain) begin
        src_valid <= 1'b0;
        if (pulse_count < exp_pulses) begin
          while (pulse_count < exp_pulses) @(posedge dest_clk);
          repeat (settle_cycles) @(posedge dest_clk);
        end else begin
          repeat (quiet_cycles) @(posedge dest_clk); // nothing to commit
        end
        check_update(test_name[t], exp_pulses, pulse_count);
        read_all(test_name[t]);
      end
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: cfg_cdc.f
design/cfg_pkg.sv
design/cdc_pkg.sv
design/cdc_bit_sync.sv
design/cdc_handshake.sv
design/axis_config_reg_cdc.sv
design/cfg_loader_fsm.sv
design/cfg_burst_counter.sv
design/cfg_reg_bank.sv
design/cfg_cdc_top.sv
tests/cfg_cdc_tb.sv
